// File: fetchPkg.sv
// Fetch package with widths, table sizes, control and miss enums and vector typedefs.
package fetchPkg;

  // Datapath widths.
  localparam int PcWidth = 32;
  localparam int InstWidth = 32;

  // Bundle geometry.
  localparam int FetchWidth = 4;
  localparam int InstBytes = 4;
  localparam int BundleBytes = FetchWidth * InstBytes;

  // Table sizes.
  localparam int BtbEntries = 16;
  localparam int BpEntries = 64;
  localparam int RasDepth = 8;
  localparam int CacheLines = 16;

  // Address field positions.
  localparam int InstOffsetW = $clog2(InstBytes);
  localparam int LineOffsetW = $clog2(BundleBytes);
  localparam int BtbIdxW = $clog2(BtbEntries);
  localparam int BpIdxW = $clog2(BpEntries);
  localparam int RasPtrW = $clog2(RasDepth);
  localparam int CacheIdxW = $clog2(CacheLines);
  localparam int BtbTagLsb = BtbIdxW + InstOffsetW;
  localparam int CacheTagLsb = CacheIdxW + LineOffsetW;

  typedef logic [PcWidth-1:0] pcT;
  typedef logic [InstWidth-1:0] instT;
  // One bundle is also one cache line.
  typedef instT [FetchWidth-1:0] bundleT;
  typedef logic [1:0] ctrT;
  typedef logic [BtbIdxW-1:0] btbIdxT;
  typedef logic [PcWidth-BtbTagLsb-1:0] btbTagT;
  typedef logic [BpIdxW-1:0] bpIdxT;
  typedef logic [RasPtrW-1:0] rasPtrT;
  typedef logic [CacheIdxW-1:0] cacheIdxT;
  typedef logic [PcWidth-CacheTagLsb-1:0] cacheTagT;

  // Control instruction types.
  typedef enum logic [1:0] {
    Return     = 2'b00,
    Call       = 2'b01,
    Jump       = 2'b10,
    CondBranch = 2'b11
  } brTypeT;

  typedef enum logic {
    MissIdle,
    MissRequest
  } missStateT;

endpackage

// File: predictIf.sv
// Per-slot prediction interface between the BTB, the direction predictor and fetch.
interface predictIf;

  // BTB results per slot.
  logic [fetchPkg::FetchWidth-1:0] hit;
  fetchPkg::brTypeT ctrlType [fetchPkg::FetchWidth];
  fetchPkg::pcT target [fetchPkg::FetchWidth];

  // Counter upper bits per slot.
  logic [fetchPkg::FetchWidth-1:0] dir;

  modport btb (
    output hit,
    output ctrlType,
    output target
  );

  modport bp (
    output dir
  );

  // Next-PC logic consumes everything.
  modport fetch (
    input hit,
    input ctrlType,
    input target,
    input dir
  );

endinterface

// File: branchTargetBuffer.sv
// Direct-mapped tagged branch target buffer with four read ports and one update port.
module branchTargetBuffer (
  input  logic              clk,
  input  logic              reset,
  input  fetchPkg::pcT      pc_i,
  input  logic              updateEn_i,
  input  fetchPkg::pcT      updatePC_i,
  input  fetchPkg::brTypeT  updateBrType_i,
  input  fetchPkg::pcT      updateTargetAddr_i,
  predictIf.btb             pred
);

  // Entry state.
  logic [fetchPkg::BtbEntries-1:0] entryValid;
  fetchPkg::btbTagT entryTag [fetchPkg::BtbEntries];
  fetchPkg::brTypeT entryType [fetchPkg::BtbEntries];
  fetchPkg::pcT entryTarget [fetchPkg::BtbEntries];

  fetchPkg::btbIdxT updateIdx;
  fetchPkg::btbTagT updateTag;

  // Word address bits above the byte offset select the entry.
  assign updateIdx = updatePC_i[fetchPkg::BtbTagLsb-1:fetchPkg::InstOffsetW];
  assign updateTag = updatePC_i[fetchPkg::PcWidth-1:fetchPkg::BtbTagLsb];

  // Valid bits.
  always_ff @(posedge clk) begin
    if (reset) begin
      entryValid <= '0;
    end else if (updateEn_i) begin
      entryValid[updateIdx] <= 1'b1;
    end
  end

  // Tag, type and target payload.
  always_ff @(posedge clk) begin
    if (updateEn_i) begin
      entryTag[updateIdx] <= updateTag;
      entryType[updateIdx] <= updateBrType_i;
      entryTarget[updateIdx] <= updateTargetAddr_i;
    end
  end

  // Four lookups, one per instruction of the bundle.
  always_comb begin
    fetchPkg::pcT slotAddr;
    fetchPkg::btbIdxT slotIdx;
    for (int s = 0; s < fetchPkg::FetchWidth; s++) begin
      slotAddr = pc_i + fetchPkg::pcT'(s * fetchPkg::InstBytes);
      slotIdx = slotAddr[fetchPkg::BtbTagLsb-1:fetchPkg::InstOffsetW];
      // Hit needs a valid entry and a full tag match.
      pred.hit[s] = entryValid[slotIdx] &&
                    (entryTag[slotIdx] == slotAddr[fetchPkg::PcWidth-1:fetchPkg::BtbTagLsb]);
      pred.ctrlType[s] = entryType[slotIdx];
      pred.target[s] = entryTarget[slotIdx];
    end
  end

endmodule

// File: bimodalPredictor.sv
// Bimodal direction predictor of 2-bit saturating counters with four slot outputs.
module bimodalPredictor (
  input  logic          clk,
  input  logic          reset,
  input  fetchPkg::pcT  pc_i,
  input  logic          updateEn_i,
  input  fetchPkg::pcT  updatePC_i,
  input  logic          updateDir_i,
  predictIf.bp          pred
);

  fetchPkg::ctrT counter [fetchPkg::BpEntries];
  fetchPkg::bpIdxT updateIdx;

  assign updateIdx = updatePC_i[fetchPkg::BpIdxW+fetchPkg::InstOffsetW-1:fetchPkg::InstOffsetW];

  // Counters start weakly not-taken.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < fetchPkg::BpEntries; i++) begin
        counter[i] <= 2'b01;
      end
    end else if (updateEn_i) begin
      if (updateDir_i) begin
        // Saturate at strongly taken.
        if (counter[updateIdx] != 2'b11) begin
          counter[updateIdx] <= counter[updateIdx] + 2'b01;
        end
      end else if (counter[updateIdx] != 2'b00) begin
        counter[updateIdx] <= counter[updateIdx] - 2'b01;
      end
    end
  end

  // Upper counter bit is the predicted direction.
  always_comb begin
    fetchPkg::pcT slotAddr;
    fetchPkg::bpIdxT slotIdx;
    for (int s = 0; s < fetchPkg::FetchWidth; s++) begin
      slotAddr = pc_i + fetchPkg::pcT'(s * fetchPkg::InstBytes);
      slotIdx = slotAddr[fetchPkg::BpIdxW+fetchPkg::InstOffsetW-1:fetchPkg::InstOffsetW];
      pred.dir[s] = counter[slotIdx][1];
    end
  end

endmodule

// File: returnAddressStack.sv
// Circular return address stack with speculative push and pop and decode repair.
module returnAddressStack (
  input  logic          clk,
  input  logic          reset,
  input  logic          push_i,
  input  fetchPkg::pcT  pushAddr_i,
  input  logic          pop_i,
  input  logic          flagRecoverID_i,
  input  logic          flagCallID_i,
  input  fetchPkg::pcT  callPCID_i,
  input  logic          flagRtrID_i,
  output fetchPkg::pcT  addrRAS_o,
  output fetchPkg::pcT  addrRAS_CP_o
);

  fetchPkg::pcT stack [fetchPkg::RasDepth];
  fetchPkg::rasPtrT topPtr;

  logic repairPush;
  logic repairPop;
  logic pushEn;
  logic popEn;
  fetchPkg::pcT pushData;

  // Decode repair overrides the bundle's own push or pop.
  assign repairPush = flagRecoverID_i & flagCallID_i;
  assign repairPop = flagRecoverID_i & flagRtrID_i & ~flagCallID_i;

  assign pushEn = repairPush | (~flagRecoverID_i & push_i);
  assign popEn = repairPop | (~flagRecoverID_i & pop_i);
  assign pushData = repairPush ? callPCID_i : pushAddr_i;

  // Top pointer wraps around the buffer.
  always_ff @(posedge clk) begin
    if (reset) begin
      topPtr <= '0;
    end else if (pushEn) begin
      topPtr <= topPtr + 1'b1;
    end else if (popEn) begin
      topPtr <= topPtr - 1'b1;
    end
  end

  // Push writes the slot above the top.
  always_ff @(posedge clk) begin
    if (pushEn) begin
      stack[topPtr + 1'b1] <= pushData;
    end
  end

  // Both views show the current top.
  assign addrRAS_o = stack[topPtr];
  assign addrRAS_CP_o = stack[topPtr];

endmodule

// File: instCache.sv
// Direct-mapped instruction cache with data, tag and valid arrays and hit detection.
module instCache (
  input  logic              clk,
  input  logic              reset,
  input  fetchPkg::pcT      addr_i,
  input  logic              wrEnable_i,
  input  fetchPkg::pcT      wrAddr_i,
  input  fetchPkg::bundleT  instBlock_i,
  output fetchPkg::bundleT  instBundle_o,
  output logic              hit_o
);

  fetchPkg::bundleT lineData [fetchPkg::CacheLines];
  fetchPkg::cacheTagT lineTag [fetchPkg::CacheLines];
  logic [fetchPkg::CacheLines-1:0] lineValid;

  fetchPkg::cacheIdxT rdIdx;
  fetchPkg::cacheIdxT wrIdx;

  assign rdIdx = addr_i[fetchPkg::CacheTagLsb-1:fetchPkg::LineOffsetW];
  assign wrIdx = wrAddr_i[fetchPkg::CacheTagLsb-1:fetchPkg::LineOffsetW];

  // Valid bits.
  always_ff @(posedge clk) begin
    if (reset) begin
      lineValid <= '0;
    end else if (wrEnable_i) begin
      lineValid[wrIdx] <= 1'b1;
    end
  end

  // Fill writes a whole line and its tag.
  always_ff @(posedge clk) begin
    if (wrEnable_i) begin
      lineData[wrIdx] <= instBlock_i;
      lineTag[wrIdx] <= wrAddr_i[fetchPkg::PcWidth-1:fetchPkg::CacheTagLsb];
    end
  end

  // Read is combinational from the PC.
  assign instBundle_o = lineData[rdIdx];
  assign hit_o = lineValid[rdIdx] &&
                 (lineTag[rdIdx] == addr_i[fetchPkg::PcWidth-1:fetchPkg::CacheTagLsb]);

endmodule

// File: missHandler.sv
// Miss FSM that raises and holds the fill request until the matching line arrives.
module missHandler (
  input  logic          clk,
  input  logic          reset,
  input  logic          hit_i,
  input  fetchPkg::pcT  addr_i,
  input  logic          wrEnable_i,
  input  fetchPkg::pcT  wrAddr_i,
  output logic          miss_o,
  output fetchPkg::pcT  missAddr_o
);

  fetchPkg::missStateT state;
  fetchPkg::pcT lineAddr;
  fetchPkg::pcT reqLine;
  logic fillMatch;

  // Line-aligned lookup address.
  assign lineAddr = {addr_i[fetchPkg::PcWidth-1:fetchPkg::LineOffsetW],
                     {fetchPkg::LineOffsetW{1'b0}}};

  // Fill for the pending line ends the request.
  assign fillMatch = wrEnable_i &&
                     (wrAddr_i[fetchPkg::PcWidth-1:fetchPkg::LineOffsetW] ==
                      reqLine[fetchPkg::PcWidth-1:fetchPkg::LineOffsetW]);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fetchPkg::MissIdle;
    end else begin
      case (state)
        fetchPkg::MissIdle: begin
          if (!hit_i) begin
            state <= fetchPkg::MissRequest;
          end
        end
        fetchPkg::MissRequest: begin
          if (fillMatch) begin
            state <= fetchPkg::MissIdle;
          end
        end
        default: state <= fetchPkg::MissIdle;
      endcase
    end
  end

  // Latch the line only on entry to the request state.
  always_ff @(posedge clk) begin
    if (state == fetchPkg::MissIdle && !hit_i) begin
      reqLine <= lineAddr;
    end
  end

  assign miss_o = (state == fetchPkg::MissRequest);
  assign missAddr_o = reqLine;

endmodule

// File: fetchStage1.sv
// Fetch stage 1 top with PC register, next-PC priority, return stack control and instances.
module fetchStage1 (
  input  logic              clk,
  input  logic              reset,
  input  logic              stall_i,
  input  logic              recoverFlag_i,
  input  fetchPkg::pcT      recoverPC_i,
  input  logic              flagRecoverID_i,
  input  logic              flagCallID_i,
  input  fetchPkg::pcT      callPCID_i,
  input  logic              flagRtrID_i,
  input  fetchPkg::pcT      targetAddrID_i,
  input  logic              flagRecoverEX_i,
  input  fetchPkg::pcT      targetAddrEX_i,
  input  fetchPkg::pcT      updatePC_i,
  input  fetchPkg::pcT      updateTargetAddr_i,
  input  fetchPkg::brTypeT  updateBrType_i,
  input  logic              updateDir_i,
  input  logic              updateEn_i,
  input  logic              wrEnable_i,
  input  fetchPkg::pcT      wrAddr_i,
  input  fetchPkg::bundleT  instBlock_i,
  output logic              fs1Ready_o,
  output fetchPkg::bundleT  instructionBundle_o,
  output fetchPkg::pcT      pc_o,
  output fetchPkg::pcT      addrRAS_CP_o,
  output logic [3:0]        btbHit_o,
  output logic [3:0]        prediction_o,
  output fetchPkg::pcT      targetAddr0_o,
  output fetchPkg::pcT      targetAddr1_o,
  output fetchPkg::pcT      targetAddr2_o,
  output fetchPkg::pcT      targetAddr3_o,
  output logic              miss_o,
  output fetchPkg::pcT      missAddr_o
);

  fetchPkg::pcT pc;
  fetchPkg::pcT rasTop;
  fetchPkg::pcT rasCp;
  logic cacheHit;
  logic hold;
  logic updateBtb;
  logic updateBp;

  logic [fetchPkg::FetchWidth-1:0] slotTaken;
  fetchPkg::pcT slotTarget [fetchPkg::FetchWidth];
  logic anyTaken;
  fetchPkg::brTypeT takenType;
  fetchPkg::pcT takenTarget;
  fetchPkg::pcT pushAddr;
  fetchPkg::pcT predPC;

  logic idRecover;
  logic predictFollow;
  logic rasPush;
  logic rasPop;

  predictIf predBus ();

  // Untaken conditionals leave the BTB alone.
  assign updateBtb = updateEn_i &
                     ((updateBrType_i != fetchPkg::CondBranch) | updateDir_i);
  assign updateBp = updateEn_i & (updateBrType_i == fetchPkg::CondBranch);

  branchTargetBuffer btb (
    .clk(clk),
    .reset(reset),
    .pc_i(pc),
    .updateEn_i(updateBtb),
    .updatePC_i(updatePC_i),
    .updateBrType_i(updateBrType_i),
    .updateTargetAddr_i(updateTargetAddr_i),
    .pred(predBus)
  );

  bimodalPredictor bp (
    .clk(clk),
    .reset(reset),
    .pc_i(pc),
    .updateEn_i(updateBp),
    .updatePC_i(updatePC_i),
    .updateDir_i(updateDir_i),
    .pred(predBus)
  );

  returnAddressStack ras (
    .clk(clk),
    .reset(reset),
    .push_i(rasPush),
    .pushAddr_i(pushAddr),
    .pop_i(rasPop),
    .flagRecoverID_i(idRecover),
    .flagCallID_i(flagCallID_i),
    .callPCID_i(callPCID_i),
    .flagRtrID_i(flagRtrID_i),
    .addrRAS_o(rasTop),
    .addrRAS_CP_o(rasCp)
  );

  instCache icache (
    .clk(clk),
    .reset(reset),
    .addr_i(pc),
    .wrEnable_i(wrEnable_i),
    .wrAddr_i(wrAddr_i),
    .instBlock_i(instBlock_i),
    .instBundle_o(instructionBundle_o),
    .hit_o(cacheHit)
  );

  missHandler missUnit (
    .clk(clk),
    .reset(reset),
    .hit_i(cacheHit),
    .addr_i(pc),
    .wrEnable_i(wrEnable_i),
    .wrAddr_i(wrAddr_i),
    .miss_o(miss_o),
    .missAddr_o(missAddr_o)
  );

  // Conditional slots need a taken counter. Returns take the stack top.
  always_comb begin
    for (int s = 0; s < fetchPkg::FetchWidth; s++) begin
      slotTaken[s] = predBus.hit[s] &
                     ((predBus.ctrlType[s] != fetchPkg::CondBranch) | predBus.dir[s]);
      slotTarget[s] = (predBus.ctrlType[s] == fetchPkg::Return) ? rasTop : predBus.target[s];
    end
  end

  // First taken slot wins. Scan from the top so slot 0 lands last.
  always_comb begin
    anyTaken = 1'b0;
    takenType = fetchPkg::Jump;
    takenTarget = pc;
    pushAddr = pc;
    for (int s = fetchPkg::FetchWidth - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        anyTaken = 1'b1;
        takenType = predBus.ctrlType[s];
        takenTarget = slotTarget[s];
        // Return address follows the call.
        pushAddr = pc + fetchPkg::pcT'((s + 1) * fetchPkg::InstBytes);
      end
    end
  end

  assign predPC = anyTaken ? takenTarget : pc + fetchPkg::pcT'(fetchPkg::BundleBytes);

  // Stall or cache miss freezes fetch.
  assign hold = stall_i | ~cacheHit;
  assign idRecover = flagRecoverID_i & ~hold & ~recoverFlag_i & ~flagRecoverEX_i;
  assign predictFollow = ~hold & ~recoverFlag_i & ~flagRecoverEX_i & ~flagRecoverID_i;

  // Stack moves only when the prediction is followed.
  assign rasPush = predictFollow & anyTaken & (takenType == fetchPkg::Call);
  assign rasPop = predictFollow & anyTaken & (takenType == fetchPkg::Return);

  // PC priority. EX recovery ignores hold.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (recoverFlag_i) begin
      pc <= recoverPC_i;
    end else if (flagRecoverEX_i) begin
      pc <= targetAddrEX_i;
    end else if (!hold) begin
      if (flagRecoverID_i) begin
        pc <= flagRtrID_i ? rasCp : targetAddrID_i;
      end else begin
        pc <= predPC;
      end
    end
  end

  // Outputs.
  assign pc_o = pc;
  assign fs1Ready_o = cacheHit;
  assign addrRAS_CP_o = rasCp;
  assign btbHit_o = predBus.hit;
  assign prediction_o = predBus.dir;
  assign targetAddr0_o = slotTarget[0];
  assign targetAddr1_o = slotTarget[1];
  assign targetAddr2_o = slotTarget[2];
  assign targetAddr3_o = slotTarget[3];

endmodule

// File: fetchStage1_props.sv
// Bound concurrent assertions on miss request hold, stalled PC and miss state in reset.
module fetchStage1_props (
  input logic          clk,
  input logic          reset,
  input logic          stall_i,
  input logic          recoverFlag_i,
  input logic          flagRecoverEX_i,
  input logic          wrEnable_i,
  input fetchPkg::pcT  wrAddr_i,
  input fetchPkg::pcT  pc_o,
  input logic          miss_o,
  input fetchPkg::pcT  missAddr_o
);

  logic fillMatch;

  // Fill for the requested line.
  assign fillMatch = wrEnable_i &&
                     (wrAddr_i[fetchPkg::PcWidth-1:fetchPkg::LineOffsetW] ==
                      missAddr_o[fetchPkg::PcWidth-1:fetchPkg::LineOffsetW]);

  // Request stays up until its own line arrives.
  missHeld: assert property (@(posedge clk) disable iff (reset)
    miss_o && !fillMatch |=> miss_o)
    else $error("miss request dropped without a matching fill");

  // Only the two late recoveries may move a stalled PC.
  stallHold: assert property (@(posedge clk) disable iff (reset)
    stall_i && !recoverFlag_i && !flagRecoverEX_i |=> $stable(pc_o))
    else $error("program counter moved during a stall");

  // Reset clears any pending request.
  resetIdle: assert property (@(posedge clk) reset |=> !miss_o)
    else $error("miss request high after a reset edge");

endmodule

bind fetchStage1 fetchStage1_props fetchProps (
  .clk(clk),
  .reset(reset),
  .stall_i(stall_i),
  .recoverFlag_i(recoverFlag_i),
  .flagRecoverEX_i(flagRecoverEX_i),
  .wrEnable_i(wrEnable_i),
  .wrAddr_i(wrAddr_i),
  .pc_o(pc_o),
  .miss_o(miss_o),
  .missAddr_o(missAddr_o)
);

// File: fetchTb.sv
// Fetch stage 1 testbench with clock, seeded random stimulus, reference model and checks.
module fetchTb;

  logic clk;
  logic reset;
  logic stall_i;
  logic recoverFlag_i;
  fetchPkg::pcT recoverPC_i;
  logic flagRecoverID_i;
  logic flagCallID_i;
  fetchPkg::pcT callPCID_i;
  logic flagRtrID_i;
  fetchPkg::pcT targetAddrID_i;
  logic flagRecoverEX_i;
  fetchPkg::pcT targetAddrEX_i;
  fetchPkg::pcT updatePC_i;
  fetchPkg::pcT updateTargetAddr_i;
  fetchPkg::brTypeT updateBrType_i;
  logic updateDir_i;
  logic updateEn_i;
  logic wrEnable_i;
  fetchPkg::pcT wrAddr_i;
  fetchPkg::bundleT instBlock_i;
  logic fs1Ready_o;
  fetchPkg::bundleT instructionBundle_o;
  fetchPkg::pcT pc_o;
  fetchPkg::pcT addrRAS_CP_o;
  logic [3:0] btbHit_o;
  logic [3:0] prediction_o;
  fetchPkg::pcT targetAddr0_o;
  fetchPkg::pcT targetAddr1_o;
  fetchPkg::pcT targetAddr2_o;
  fetchPkg::pcT targetAddr3_o;
  logic miss_o;
  fetchPkg::pcT missAddr_o;

  // Reference model state.
  fetchPkg::pcT mPc;
  logic mBtbValid [fetchPkg::BtbEntries];
  fetchPkg::pcT mBtbPc [fetchPkg::BtbEntries];
  fetchPkg::brTypeT mBtbType [fetchPkg::BtbEntries];
  fetchPkg::pcT mBtbTarget [fetchPkg::BtbEntries];
  fetchPkg::ctrT mCtr [fetchPkg::BpEntries];
  fetchPkg::pcT mRas [fetchPkg::RasDepth];
  logic mRasValid [fetchPkg::RasDepth];
  int mRasTop;
  logic mLineValid [fetchPkg::CacheLines];
  fetchPkg::pcT mLineAddr [fetchPkg::CacheLines];
  logic mMiss;
  fetchPkg::pcT mMissAddr;

  integer seed;
  int errors;
  int checks;
  int fillDelay;
  int presets;
  string testName;

  fetchStage1 dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int pick(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Word-aligned address inside the first kilobyte.
  function automatic fetchPkg::pcT randAddr();
    return fetchPkg::pcT'($random(seed)) & 32'h3fc;
  endfunction

  function automatic fetchPkg::pcT lineOf(fetchPkg::pcT a);
    return a & ~fetchPkg::pcT'(fetchPkg::BundleBytes - 1);
  endfunction

  // Memory contents, a mix of every address bit.
  function automatic fetchPkg::instT memWord(fetchPkg::pcT a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic fetchPkg::bundleT memLine(fetchPkg::pcT a);
    fetchPkg::bundleT line;
    for (int w = 0; w < fetchPkg::FetchWidth; w++) begin
      line[w] = memWord(lineOf(a) + fetchPkg::pcT'(4 * w));
    end
    return line;
  endfunction

  function automatic logic modelHit();
    int idx;
    idx = int'((mPc >> 4) % fetchPkg::CacheLines);
    return mLineValid[idx] && (mLineAddr[idx] == lineOf(mPc));
  endfunction

  function automatic fetchPkg::pcT slotAddr(int s);
    return mPc + fetchPkg::pcT'(4 * s);
  endfunction

  function automatic int btbIdx(fetchPkg::pcT a);
    return int'((a >> 2) % fetchPkg::BtbEntries);
  endfunction

  function automatic int ctrIdx(fetchPkg::pcT a);
    return int'((a >> 2) % fetchPkg::BpEntries);
  endfunction

  // Tag is everything above the entry index.
  function automatic logic slotHit(int s);
    int idx;
    idx = btbIdx(slotAddr(s));
    return mBtbValid[idx] && ((mBtbPc[idx] >> 6) == (slotAddr(s) >> 6));
  endfunction

  function automatic logic slotTaken(int s);
    int idx;
    idx = btbIdx(slotAddr(s));
    if (!slotHit(s)) return 1'b0;
    return (mBtbType[idx] != fetchPkg::CondBranch) || (mCtr[ctrIdx(slotAddr(s))] >= 2'd2);
  endfunction

  function automatic fetchPkg::pcT slotTarget(int s);
    int idx;
    idx = btbIdx(slotAddr(s));
    return (mBtbType[idx] == fetchPkg::Return) ? mRas[mRasTop] : mBtbTarget[idx];
  endfunction

  task automatic checkValue(string what, logic [127:0] expVal, logic [127:0] actVal);
    checks++;
    assert (actVal === expVal) else begin
      errors++;
      $display("Fail %s %s: expected %0h, actual %0h", testName, what, expVal, actVal);
    end
  endtask

  task automatic checkOutputs();
    fetchPkg::pcT dutTarget [fetchPkg::FetchWidth];
    logic [3:0] expHit;
    logic [3:0] expDir;
    dutTarget[0] = targetAddr0_o;
    dutTarget[1] = targetAddr1_o;
    dutTarget[2] = targetAddr2_o;
    dutTarget[3] = targetAddr3_o;
    checkValue("pc_o", mPc, pc_o);
    checkValue("fs1Ready_o", modelHit(), fs1Ready_o);
    checkValue("miss_o", mMiss, miss_o);
    if (mMiss) checkValue("missAddr_o", mMissAddr, missAddr_o);
    if (modelHit()) checkValue("instructionBundle_o", memLine(mPc), instructionBundle_o);
    for (int s = 0; s < fetchPkg::FetchWidth; s++) begin
      expHit[s] = slotHit(s);
      expDir[s] = mCtr[ctrIdx(slotAddr(s))][1];
      if (expHit[s]) checkValue("slot target", slotTarget(s), dutTarget[s]);
    end
    checkValue("btbHit_o", expHit, btbHit_o);
    checkValue("prediction_o", expDir, prediction_o);
    // Unwritten stack slots hold no known value.
    if (mRasValid[mRasTop]) checkValue("addrRAS_CP_o", mRas[mRasTop], addrRAS_CP_o);
  endtask

  task automatic clearInputs();
    stall_i = 1'b0;
    recoverFlag_i = 1'b0;
    recoverPC_i = '0;
    flagRecoverID_i = 1'b0;
    flagCallID_i = 1'b0;
    callPCID_i = '0;
    flagRtrID_i = 1'b0;
    targetAddrID_i = '0;
    flagRecoverEX_i = 1'b0;
    targetAddrEX_i = '0;
    updatePC_i = '0;
    updateTargetAddr_i = '0;
    updateBrType_i = fetchPkg::Jump;
    updateDir_i = 1'b0;
    updateEn_i = 1'b0;
    wrEnable_i = 1'b0;
    wrAddr_i = '0;
    instBlock_i = '0;
  endtask

  task automatic resetModel();
    mPc = '0;
    mRasTop = 0;
    mMiss = 1'b0;
    mMissAddr = '0;
    for (int i = 0; i < fetchPkg::BtbEntries; i++) mBtbValid[i] = 1'b0;
    for (int i = 0; i < fetchPkg::BpEntries; i++) mCtr[i] = 2'b01;
    for (int i = 0; i < fetchPkg::RasDepth; i++) mRasValid[i] = 1'b0;
    for (int i = 0; i < fetchPkg::CacheLines; i++) mLineValid[i] = 1'b0;
  endtask

  task automatic rasPush(fetchPkg::pcT value);
    mRasTop = (mRasTop + 1) % fetchPkg::RasDepth;
    mRas[mRasTop] = value;
    mRasValid[mRasTop] = 1'b1;
  endtask

  // Mode 1 fills the stack through decode call repairs.
  task automatic chooseInputs(int mode, int updPct, int recPct, int stallPct, int span);
    clearInputs();
    if (mode == 1) begin
      if (modelHit()) begin
        flagRecoverID_i = 1'b1;
        flagCallID_i = 1'b1;
        callPCID_i = randAddr();
        targetAddrID_i = mPc;
        presets++;
      end
    end else begin
      stall_i = pick(100) < stallPct;
      recoverFlag_i = pick(100) < recPct;
      recoverPC_i = randAddr();
      flagRecoverEX_i = pick(100) < recPct;
      targetAddrEX_i = randAddr();
      flagRecoverID_i = pick(100) < recPct;
      flagRtrID_i = flagRecoverID_i && (pick(2) == 1);
      flagCallID_i = flagRecoverID_i && (pick(2) == 1);
      targetAddrID_i = randAddr();
      callPCID_i = randAddr();
      updateEn_i = pick(100) < updPct;
      updatePC_i = randAddr();
      updateTargetAddr_i = randAddr();
      updateBrType_i = fetchPkg::brTypeT'(2'(3 - pick(span)));
      updateDir_i = pick(4) != 0;
      // Pull a runaway PC back into the test region.
      if (mPc > 32'h3ff) begin
        flagRecoverEX_i = 1'b1;
        targetAddrEX_i = randAddr();
      end
    end
    // Memory answers a request after a random delay.
    if (miss_o) begin
      if (fillDelay < 0) fillDelay = pick(4);
      if (fillDelay == 0) begin
        wrEnable_i = 1'b1;
        wrAddr_i = missAddr_o;
        instBlock_i = memLine(missAddr_o);
      end
      fillDelay--;
    end else begin
      fillDelay = -1;
    end
  endtask

  // Advance the model across one clock edge.
  task automatic stepModel();
    logic hold;
    logic idRec;
    logic follow;
    int first;
    int idx;
    fetchPkg::brTypeT takenType;
    fetchPkg::pcT nextPc;
    hold = stall_i || !modelHit();
    first = -1;
    for (int s = 0; s < fetchPkg::FetchWidth; s++) begin
      if (first < 0 && slotTaken(s)) first = s;
    end
    takenType = (first >= 0) ? mBtbType[btbIdx(slotAddr(first))] : fetchPkg::Jump;
    idRec = 1'b0;
    follow = 1'b0;
    nextPc = mPc;
    if (recoverFlag_i) begin
      nextPc = recoverPC_i;
    end else if (flagRecoverEX_i) begin
      nextPc = targetAddrEX_i;
    end else if (!hold && flagRecoverID_i) begin
      idRec = 1'b1;
      nextPc = flagRtrID_i ? mRas[mRasTop] : targetAddrID_i;
    end else if (!hold) begin
      follow = 1'b1;
      nextPc = (first >= 0) ? slotTarget(first) : mPc + 32'd16;
    end
    // Stack repair first, then the bundle's own call or return.
    if (idRec && flagCallID_i) begin
      rasPush(callPCID_i);
    end else if (idRec && flagRtrID_i) begin
      mRasTop = (mRasTop + fetchPkg::RasDepth - 1) % fetchPkg::RasDepth;
    end else if (follow && first >= 0 && takenType == fetchPkg::Call) begin
      rasPush(mPc + fetchPkg::pcT'(4 * first + 4));
    end else if (follow && first >= 0 && takenType == fetchPkg::Return) begin
      mRasTop = (mRasTop + fetchPkg::RasDepth - 1) % fetchPkg::RasDepth;
    end
    // Miss FSM sees the cache before the fill lands.
    if (!mMiss && !modelHit()) begin
      mMiss = 1'b1;
      mMissAddr = lineOf(mPc);
    end else if (mMiss && wrEnable_i && lineOf(wrAddr_i) == mMissAddr) begin
      mMiss = 1'b0;
    end
    if (wrEnable_i) begin
      idx = int'((wrAddr_i >> 4) % fetchPkg::CacheLines);
      mLineValid[idx] = 1'b1;
      mLineAddr[idx] = lineOf(wrAddr_i);
    end
    if (updateEn_i && (updateBrType_i != fetchPkg::CondBranch || updateDir_i)) begin
      idx = btbIdx(updatePC_i);
      mBtbValid[idx] = 1'b1;
      mBtbPc[idx] = updatePC_i;
      mBtbType[idx] = updateBrType_i;
      mBtbTarget[idx] = updateTargetAddr_i;
    end
    if (updateEn_i && updateBrType_i == fetchPkg::CondBranch) begin
      idx = ctrIdx(updatePC_i);
      if (updateDir_i && mCtr[idx] != 2'd3) mCtr[idx] = mCtr[idx] + 2'd1;
      else if (!updateDir_i && mCtr[idx] != 2'd0) mCtr[idx] = mCtr[idx] - 2'd1;
    end
    mPc = nextPc;
  endtask

  // Check and drive at the falling edge, model at the rising edge.
  task automatic stepCycle(int mode, int updPct, int recPct, int stallPct, int span);
    checkOutputs();
    chooseInputs(mode, updPct, recPct, stallPct, span);
    @(posedge clk);
    stepModel();
    @(negedge clk);
  endtask

  task automatic runPhase(string name, int cycles, int updPct, int recPct, int stallPct,
                          int span);
    testName = name;
    repeat (cycles) stepCycle(0, updPct, recPct, stallPct, span);
  endtask

  task automatic waitReady(int limit);
    int n;
    testName = "missHandling";
    n = 0;
    while (!fs1Ready_o && n < limit) begin
      stepCycle(0, 0, 0, 0, 2);
      n++;
    end
    assert (fs1Ready_o) else begin
      errors++;
      $display("Timeout: the first cache miss was never filled");
    end
  endtask

  task automatic presetStack(int limit);
    int n;
    testName = "rasPreset";
    presets = 0;
    n = 0;
    while (presets < fetchPkg::RasDepth && n < limit) begin
      stepCycle(1, 0, 0, 0, 2);
      n++;
    end
    assert (presets >= fetchPkg::RasDepth) else begin
      errors++;
      $display("Timeout: the return stack could not be filled by decode repairs");
    end
  endtask

  initial begin
    seed = 32'hccf6;
    errors = 0;
    checks = 0;
    fillDelay = -1;
    clearInputs();
    reset = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    resetModel();
    waitReady(20);
    runPhase("sequential", 40, 0, 0, 0, 2);
    presetStack(200);
    runPhase("prediction", 150, 30, 0, 0, 2);
    runPhase("callReturn", 150, 30, 0, 0, 4);
    runPhase("recovery", 200, 10, 8, 20, 4);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: project.f
fetchPkg.sv
predictIf.sv
branchTargetBuffer.sv
bimodalPredictor.sv
returnAddressStack.sv
instCache.sv
missHandler.sv
fetchStage1.sv
fetchStage1_props.sv
fetchTb.sv

// File: run.sh
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fetchTb -f project.f -o fetchSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/fetchSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
